/* design/spi_pkg.sv */
package spi_pkg;

    // Clock cycles per SCLK half-period, minus one
    typedef logic [11:0] spi_div_t;

    // Delays counted in SCLK half-periods
    typedef logic [7:0] spi_dly_t;

    // Frame length in bits is size + 1
    typedef logic [3:0] spi_size_t;

    // SCLK edges within one frame, up to 32
    typedef logic [4:0] spi_edge_t;

    typedef enum logic [1:0] {
        // Deselect after every frame
        CS_PER_FRAME = 2'd0,
        // Keep select low while words are queued
        CS_HOLD      = 2'd1
    } spi_cs_mode_e;

    typedef struct packed {
        spi_div_t     div;
        logic         cpol;
        logic         cpha;
        spi_cs_mode_e cs_mode;
        // Select to first edge
        spi_dly_t     c2t;
        // Last edge to deselect
        spi_dly_t     t2c;
        // Minimum deselect time
        spi_dly_t     inter_cs;
        // Gap between frames in CS_HOLD
        spi_dly_t     inter_frame;
        spi_size_t    size;
    } spi_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT,
        ST_TRANS,
        ST_TURN,
        ST_INTERVAL
    } spi_state_e;

endpackage

/* design/spi_fifo.sv */
`timescale 1ns/1ps

module spi_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == CW'(DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head of queue, valid while not empty
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap so any depth works
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* design/spi_controller.sv */
`timescale 1ns/1ps

module spi_controller
    import spi_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  spi_cfg_t cfg_i,
    input  logic     tx_empty_i,
    output logic     tx_pop_o,
    output logic     rx_push_o,
    output logic     shift_o,
    output logic     sample_o,
    output logic     sclk_o,
    output logic     cs_n_o,
    output logic     busy_o
);

    spi_state_e state_q;
    spi_state_e state_d;
    logic       state_chg;

    // Half-period divider
    spi_div_t   div_cnt;
    logic       half_end;

    // Delay counter shared by the waiting states
    spi_dly_t   dly_cnt;
    spi_dly_t   dly_target;
    logic       dly_done;

    // SCLK edges within the current frame
    spi_edge_t  edge_cnt;
    logic       last_edge;
    logic       trans_edge;

    logic       sclk_tgl_q;
    logic       cs_ok_q;
    logic       entry_q;
    logic       rx_push_q;

    assign half_end  = (div_cnt == cfg_i.div);
    assign state_chg = (state_d != state_q);

    // Frame ends on edge 2*size+1
    assign last_edge  = (edge_cnt == {cfg_i.size, 1'b1});
    assign trans_edge = (state_q == ST_TRANS) && half_end;

    always_comb begin
        case (state_q)
            ST_WAIT:     dly_target = cfg_i.c2t;
            ST_TURN:     dly_target = cfg_i.inter_frame;
            ST_INTERVAL: dly_target = cfg_i.t2c;
            default:     dly_target = cfg_i.inter_cs;
        endcase
    end

    // True on the cycle that closes the last half-period of the delay
    assign dly_done = (dly_target == '0) ||
                      (half_end && (dly_cnt + 8'd1 == dly_target));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if ((cs_ok_q || dly_done) && !tx_empty_i) begin
                    state_d = ST_LOAD;
                end
            end
            ST_LOAD: begin
                state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (dly_done) begin
                    state_d = ST_TRANS;
                end
            end
            ST_TRANS: begin
                if (half_end && last_edge) begin
                    if ((cfg_i.cs_mode == CS_HOLD) && !tx_empty_i) begin
                        state_d = ST_TURN;
                    end else begin
                        state_d = ST_INTERVAL;
                    end
                end
            end
            ST_TURN: begin
                if (dly_done) begin
                    state_d = ST_TRANS;
                end
            end
            ST_INTERVAL: begin
                if (dly_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Divider and delay counters restart on every state change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            dly_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            if (state_chg || half_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (state_chg) begin
                dly_cnt <= '0;
            end else if (half_end) begin
                dly_cnt <= dly_cnt + 1'b1;
            end

            if (state_chg) begin
                edge_cnt <= '0;
            end else if (trans_edge) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
        end
    end

    // SCLK kept as a toggle relative to cpol
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_tgl_q <= 1'b0;
        end else if (trans_edge) begin
            sclk_tgl_q <= ~sclk_tgl_q;
        end else if (state_q != ST_TRANS) begin
            sclk_tgl_q <= 1'b0;
        end
    end

    // Minimum deselect time, satisfied out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_ok_q <= 1'b1;
        end else if ((state_q == ST_INTERVAL) && state_chg) begin
            cs_ok_q <= 1'b0;
        end else if ((state_q == ST_IDLE) && dly_done) begin
            cs_ok_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_q   <= 1'b0;
            rx_push_q <= 1'b0;
        end else begin
            entry_q   <= state_chg;
            // One cycle late so the last sampled bit is in the word
            rx_push_q <= trans_edge && last_edge;
        end
    end

    // Even edges lead; cpha picks which of them samples
    assign sample_o = trans_edge && (edge_cnt[0] == cfg_i.cpha);
    assign shift_o  = trans_edge && (edge_cnt[0] != cfg_i.cpha);

    assign tx_pop_o  = (state_q == ST_LOAD) || ((state_q == ST_TURN) && entry_q);
    assign rx_push_o = rx_push_q;
    assign sclk_o    = cfg_i.cpol ^ sclk_tgl_q;
    assign cs_n_o    = (state_q == ST_IDLE);
    assign busy_o    = !((state_q == ST_IDLE) || (state_q == ST_TURN));

endmodule

/* design/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter
    import spi_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  spi_size_t         size_i,
    input  logic              cpha_i,
    input  logic              load_i,
    input  logic [DATA_W-1:0] tx_word_i,
    input  logic              shift_i,
    input  logic              sample_i,
    input  logic              miso_i,
    output logic              mosi_o,
    output logic [DATA_W-1:0] rx_word_o
);

    logic [DATA_W-1:0] aligned;
    logic [DATA_W-1:0] tx_q;
    logic [DATA_W-1:0] rx_q;
    logic              mosi_q;

    // Bit size moves up to the MSB
    assign aligned = tx_word_i << (DATA_W - 1 - int'(size_i));

    always_ff @(posedge clk) begin
        if (load_i) begin
            // cpha=0 puts the first bit on MOSI at load
            tx_q <= cpha_i ? aligned : (aligned << 1);
        end else if (shift_i) begin
            tx_q <= tx_q << 1;
        end

        // Cleared at load so the result is right-aligned
        if (load_i) begin
            rx_q <= '0;
        end else if (sample_i) begin
            rx_q <= {rx_q[DATA_W-2:0], miso_i};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mosi_q <= 1'b0;
        end else if (load_i && !cpha_i) begin
            mosi_q <= aligned[DATA_W-1];
        end else if (shift_i) begin
            mosi_q <= tx_q[DATA_W-1];
        end
    end

    assign mosi_o    = mosi_q;
    assign rx_word_o = rx_q;

endmodule

/* design/spi_host.sv */
`timescale 1ns/1ps

module spi_host
    import spi_pkg::*;
#(
    parameter int DATA_W     = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  spi_cfg_t          cfg_i,
    input  logic              tx_push_i,
    input  logic [DATA_W-1:0] tx_data_i,
    output logic              tx_full_o,
    input  logic              rx_pop_i,
    output logic [DATA_W-1:0] rx_data_o,
    output logic              rx_empty_o,
    output logic              busy_o,
    output logic              sclk_o,
    output logic              cs_n_o,
    output logic              mosi_o,
    input  logic              miso_i
);

    logic [DATA_W-1:0] tx_head;
    logic [DATA_W-1:0] rx_word;
    logic              tx_empty;
    logic              tx_pop;
    logic              rx_push;
    logic              shift;
    logic              sample;

    spi_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (FIFO_DEPTH)
    ) u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (tx_push_i),
        .data_i  (tx_data_i),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .full_o  (tx_full_o),
        .empty_o (tx_empty)
    );

    spi_controller u_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg_i),
        .tx_empty_i (tx_empty),
        .tx_pop_o   (tx_pop),
        .rx_push_o  (rx_push),
        .shift_o    (shift),
        .sample_o   (sample),
        .sclk_o     (sclk_o),
        .cs_n_o     (cs_n_o),
        .busy_o     (busy_o)
    );

    // Loads the FIFO head on the same pop strobe
    spi_shifter #(
        .DATA_W (DATA_W)
    ) u_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .size_i    (cfg_i.size),
        .cpha_i    (cfg_i.cpha),
        .load_i    (tx_pop),
        .tx_word_i (tx_head),
        .shift_i   (shift),
        .sample_i  (sample),
        .miso_i    (miso_i),
        .mosi_o    (mosi_o),
        .rx_word_o (rx_word)
    );

    // No back-pressure, words are dropped when full
    spi_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (FIFO_DEPTH)
    ) u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (rx_push),
        .data_i  (rx_word),
        .pop_i   (rx_pop_i),
        .data_o  (rx_data_o),
        .full_o  (),
        .empty_o (rx_empty_o)
    );

endmodule

/* tb/spi_host_sva.sv */
`timescale 1ns/1ps

module spi_host_sva
    import spi_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input spi_cfg_t cfg_i,
    input logic     sclk_i,
    input logic     cs_n_i,
    input logic     busy_i,
    input logic     tx_pop_i,
    input logic     tx_empty_i
);

    // SCLK rests at the idle level while deselected
    sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n_i |-> (sclk_i == cfg_i.cpol))
        else $error("sclk_o left its idle level while cs_n_o was high");

    cs_released: assert property (@(posedge clk) disable iff (!rst_n)
        ((cfg_i.cs_mode == CS_PER_FRAME) && !busy_i) |-> cs_n_i)
        else $error("cs_n_o low while not busy in per-frame mode");

    pop_guard: assert property (@(posedge clk) disable iff (!rst_n)
        tx_pop_i |-> !tx_empty_i)
        else $error("transmit FIFO popped while empty");

endmodule

bind spi_host spi_host_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_i      (cfg_i),
    .sclk_i     (sclk_o),
    .cs_n_i     (cs_n_o),
    .busy_i     (busy_o),
    .tx_pop_i   (tx_pop),
    .tx_empty_i (tx_empty)
);

/* tb/spi_host_tb.sv */
`timescale 1ns/1ps

module spi_host_tb
    import spi_pkg::*;
();

    localparam int DATA_W     = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_CASES  = 7;
    localparam int TIMEOUT    = 5000;

    typedef struct packed {
        logic         cpol;
        logic         cpha;
        spi_div_t     div;
        spi_size_t    size;
        spi_cs_mode_e cs_mode;
        spi_dly_t     c2t;
        spi_dly_t     t2c;
        spi_dly_t     inter_cs;
        spi_dly_t     inter_frame;
        logic [2:0]   words;
        logic [15:0]  first_word;
    } case_row_t;

    logic              clk;
    logic              rst_n;
    spi_cfg_t          cfg;
    logic              tx_push;
    logic [DATA_W-1:0] tx_data;
    logic              tx_full;
    logic              rx_pop;
    logic [DATA_W-1:0] rx_data;
    logic              rx_empty;
    logic              busy;
    logic              sclk;
    logic              cs_n;
    logic              mosi;

    case_row_t         cases [NUM_CASES];
    logic [DATA_W-1:0] sent [$];
    integer            seed;
    int                case_idx;

    // Bus monitor state
    int   cyc        = 0;
    int   last_tgl   = 0;
    int   frame_tgl  = 0;
    int   sclk_rises = 0;
    int   cs_rises   = 0;
    logic sclk_prev  = 1'b0;
    logic cs_prev    = 1'b1;

    spi_host #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_i      (cfg),
        .tx_push_i  (tx_push),
        .tx_data_i  (tx_data),
        .tx_full_o  (tx_full),
        .rx_pop_i   (rx_pop),
        .rx_data_o  (rx_data),
        .rx_empty_o (rx_empty),
        .busy_o     (busy),
        .sclk_o     (sclk),
        .cs_n_o     (cs_n),
        .mosi_o     (mosi),
        // Loopback
        .miso_i     (mosi)
    );

    always #4 clk = ~clk;

    // Sees the values that settled during the previous cycle
    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (!cs_n && (sclk != sclk_prev)) begin
                // First toggle of a frame follows a delay state
                if (frame_tgl != 0) begin
                    check_value("sclk half-period", cyc - last_tgl, int'(cfg.div) + 1);
                end
                last_tgl  = cyc;
                frame_tgl = frame_tgl + 1;
                if (frame_tgl == 2 * (int'(cfg.size) + 1)) begin
                    frame_tgl = 0;
                end
                if (sclk) begin
                    sclk_rises = sclk_rises + 1;
                end
            end
            if (!cs_prev && cs_n) begin
                cs_rises = cs_rises + 1;
            end
        end
        sclk_prev = sclk;
        cs_prev   = cs_n;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_idle(input logic cpol);
        check_value("cs_n_o", 32'(cs_n), 1);
        check_value("sclk_o", 32'(sclk), 32'(cpol));
        check_value("busy_o", 32'(busy), 0);
        check_value("tx_full_o", 32'(tx_full), 0);
    endtask

    task automatic wait_rx_word();
        int t;
        t = 0;
        while (rx_empty && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (rx_empty) begin
            abort_run("no received word arrived in time");
        end
    endtask

    // Done once all SCLK rises are seen and the select is released
    task automatic wait_done(input int rise_goal);
        int t;
        t = 0;
        while (!(sclk_rises >= rise_goal && cs_n && !busy) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!(sclk_rises >= rise_goal && cs_n && !busy)) begin
            abort_run("the burst did not finish in time");
        end
    endtask

    task automatic run_case(input case_row_t row);
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] word;
        int                rise_base;
        int                cs_base;
        int                bits;
        int                n;
        bits = int'(row.size) + 1;
        mask = DATA_W'((32'd1 << bits) - 32'd1);
        cfg.div         = row.div;
        cfg.cpol        = row.cpol;
        cfg.cpha        = row.cpha;
        cfg.cs_mode     = row.cs_mode;
        cfg.c2t         = row.c2t;
        cfg.t2c         = row.t2c;
        cfg.inter_cs    = row.inter_cs;
        cfg.inter_frame = row.inter_frame;
        cfg.size        = row.size;
        rise_base = sclk_rises;
        cs_base   = cs_rises;
        sent.delete();
        @(negedge clk);
        for (n = 0; n < int'(row.words); n++) begin
            // Fewer than FIFO_DEPTH words are queued before this push
            check_value("tx_full_o", 32'(tx_full), 0);
            word = (n == 0) ? row.first_word : DATA_W'($random(seed));
            sent.push_back(word);
            tx_push = 1'b1;
            tx_data = word;
            @(negedge clk);
        end
        tx_push = 1'b0;
        wait_rx_word();
        wait_done(rise_base + bits * int'(row.words));
        repeat (4) @(negedge clk);
        check_idle(row.cpol);
        for (n = 0; n < sent.size(); n++) begin
            check_value("rx_empty_o", 32'(rx_empty), 0);
            check_value("rx_data_o", 32'(rx_data), 32'(sent[n] & mask));
            rx_pop = 1'b1;
            @(negedge clk);
        end
        rx_pop = 1'b0;
        check_value("rx_empty_o", 32'(rx_empty), 1);
        check_value("sclk rises", sclk_rises - rise_base, bits * int'(row.words));
        check_value("cs_n rises", cs_rises - cs_base,
                    (row.cs_mode == CS_HOLD) ? 1 : int'(row.words));
    endtask

    // cpol cpha div size mode c2t t2c inter_cs inter_frame words first
    task automatic fill_table();
        cases[0] = '{1'b0, 1'b0, 12'd0, 4'd7, CS_PER_FRAME, 8'd1, 8'd1, 8'd2, 8'd0, 3'd3, 16'h00A5};
        cases[1] = '{1'b0, 1'b1, 12'd3, 4'd15, CS_HOLD, 8'd2, 8'd1, 8'd1, 8'd2, 3'd4, 16'hC3E1};
        cases[2] = '{1'b1, 1'b0, 12'd3, 4'd0, CS_PER_FRAME, 8'd0, 8'd0, 8'd0, 8'd0, 3'd4, 16'h0001};
        cases[3] = '{1'b1, 1'b1, 12'd0, 4'd15, CS_HOLD, 8'd1, 8'd2, 8'd3, 8'd1, 3'd3, 16'h8001};
        cases[4] = '{1'b0, 1'b0, 12'd1, 4'd0, CS_HOLD, 8'd0, 8'd0, 8'd0, 8'd0, 3'd2, 16'hFFFE};
        cases[5] = '{1'b1, 1'b1, 12'd3, 4'd7, CS_PER_FRAME, 8'd3, 8'd2, 8'd4, 8'd0, 3'd2, 16'h5A5A};
        cases[6] = '{1'b0, 1'b1, 12'd0, 4'd7, CS_HOLD, 8'd0, 8'd1, 8'd0, 8'd0, 3'd4, 16'h1234};
    endtask

    initial begin
        seed    = 32'h4872_2382;
        clk     = 1'b0;
        rst_n   = 1'b0;
        cfg     = '0;
        tx_push = 1'b0;
        tx_data = '0;
        rx_pop  = 1'b0;
        fill_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle(1'b0);
        check_value("rx_empty_o", 32'(rx_empty), 1);
        for (case_idx = 0; case_idx < NUM_CASES; case_idx++) begin
            run_case(cases[case_idx]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* src.f */
design/spi_pkg.sv
design/spi_fifo.sv
design/spi_controller.sv
design/spi_shifter.sv
design/spi_host.sv
tb/spi_host_sva.sv
tb/spi_host_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= spi_host_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
